/* logic/hand_bus_pkg.sv */
package hand_bus_pkg;

	localparam int NUM_MOTORS = 4;
	localparam int HEADER_LEN = 4;

	localparam logic [31:0] STATUS_REQUEST_HEADER = 32'hABADBABE;
	localparam logic [31:0] STATUS_RESPONSE_HEADER = 32'hB000B135;
	localparam logic [31:0] HAND_COMMAND_HEADER = 32'hB105F00D;
	localparam logic [31:0] CONTROL_MODE_HEADER = 32'hB16B00B5;

	// whole frame incl. header and crc
	localparam int STATUS_REQUEST_LEN = 7;
	localparam int STATUS_RESPONSE_LEN = 32;
	localparam int HAND_COMMAND_LEN = 15;
	localparam int CONTROL_MODE_LEN = 8;

	typedef enum logic [1:0] {
		KIND_STATUS_REQUEST,
		KIND_HAND_COMMAND,
		KIND_CONTROL_MODE
	} frame_kind_t;

	typedef logic signed [15:0] setpoint_t;
	typedef logic signed [15:0] current_t;
	typedef logic [1:0] mode_t;

	// ccitt 1021, msb first, one byte per call
	function automatic logic [15:0] crc16_next(
		input logic [7:0] data,
		input logic [15:0] crc
	);
		logic [15:0] c;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			if (c[15] ^ data[i]) begin
				c = {c[14:0], 1'b0} ^ 16'h1021;
			end else begin
				c = {c[14:0], 1'b0};
			end
		end
		return c;
	endfunction

endpackage

/* logic/frame_req_if.sv */
`timescale 1ns/1ns

interface frame_req_if;
	import hand_bus_pkg::*;

	logic send; // one-cycle strobe, only while !busy
	frame_kind_t kind;
	logic busy;
	logic done; // after last stop bit

	modport ctrl (output send, output kind, input busy, input done);
	modport sender (input send, input kind, output busy, output done);

endinterface

/* logic/status_if.sv */
`timescale 1ns/1ns

interface status_if;

	logic resp_ok;
	logic crc_error;
	// valid together with resp_ok
	logic mode_mismatch;
	logic setpoint_mismatch;

	modport receiver (output resp_ok, output crc_error,
		output mode_mismatch, output setpoint_mismatch);
	modport ctrl (input resp_ok, input crc_error,
		input mode_mismatch, input setpoint_mismatch);

endinterface

/* logic/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [7:0] data,
	output logic line,
	output logic busy,
	output logic done
);
	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	logic [CW-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [8:0] shift; // data lsb first, then stop bit
	logic bit_end;

	assign bit_end = busy && baud_cnt == CW'(CLKS_PER_BIT - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			line <= 1'b1;
			busy <= 1'b0;
			done <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					line <= 1'b0; // start bit
					busy <= 1'b1;
					baud_cnt <= '0;
					bit_cnt <= '0;
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					line <= shift[0];
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + CW'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			shift <= {1'b1, data};
		end else if (bit_end) begin
			shift <= {1'b1, shift[8:1]};
		end
	end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input logic line,
	output logic valid,
	output logic [7:0] data
);
	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	logic [1:0] sync;
	logic rx_prev;
	logic active;
	logic [CW-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic sample;

	assign sample = active && baud_cnt == CW'(CLKS_PER_BIT - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync <= 2'b11;
			rx_prev <= 1'b1;
			active <= 1'b0;
			valid <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			sync <= {sync[0], line};
			rx_prev <= sync[1];
			valid <= 1'b0;
			if (!active) begin
				if (rx_prev && !sync[1]) begin
					active <= 1'b1;
					// preload so the first sample lands mid start bit
					baud_cnt <= CW'(CLKS_PER_BIT - CLKS_PER_BIT / 2);
					bit_cnt <= '0;
				end
			end else if (sample) begin
				baud_cnt <= '0;
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt == 4'd0 && sync[1]) begin
					active <= 1'b0; // glitch, not a start bit
				end else if (bit_cnt == 4'd9) begin
					active <= 1'b0;
					valid <= sync[1]; // framing check
				end
			end else begin
				baud_cnt <= baud_cnt + CW'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
			data <= {sync[1], data[7:1]};
		end
	end

endmodule

/* logic/frame_sender.sv */
`timescale 1ns/1ns

module frame_sender #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	frame_req_if.sender req,
	input logic [7:0] node_id,
	input hand_bus_pkg::setpoint_t setpoint [hand_bus_pkg::NUM_MOTORS],
	input hand_bus_pkg::mode_t control_mode [hand_bus_pkg::NUM_MOTORS],
	output logic tx_o,
	output logic tx_enable
);
	import hand_bus_pkg::*;

	frame_kind_t kind_r, cur_kind;
	logic [3:0] idx_r, cur_idx, frame_len, sp_off;
	logic [7:0] id_r, modes_r, tx_byte;
	setpoint_t setpoint_r [NUM_MOTORS];
	setpoint_t sp;
	logic [15:0] crc_r;
	logic [31:0] header;
	logic busy_r, accept, tx_start, tx_busy, tx_done, frame_done;

	assign accept = req.send && !busy_r && !tx_busy;
	assign cur_kind = accept ? req.kind : kind_r;
	assign cur_idx = accept ? 4'd0 : idx_r; // idx_r points at the next byte
	assign tx_start = accept || (busy_r && tx_done && idx_r != frame_len);
	assign frame_done = busy_r && tx_done && idx_r == frame_len;

	always_comb begin
		case (cur_kind)
			KIND_HAND_COMMAND: header = HAND_COMMAND_HEADER;
			KIND_CONTROL_MODE: header = CONTROL_MODE_HEADER;
			default: header = STATUS_REQUEST_HEADER;
		endcase
		case (kind_r)
			KIND_HAND_COMMAND: frame_len = 4'(HAND_COMMAND_LEN);
			KIND_CONTROL_MODE: frame_len = 4'(CONTROL_MODE_LEN);
			default: frame_len = 4'(STATUS_REQUEST_LEN);
		endcase
		sp_off = cur_idx - 4'd5; // setpoints start at byte 5
		sp = setpoint_r[sp_off[2:1]];
		if (cur_idx < 4'(HEADER_LEN)) begin
			tx_byte = 8'(header >> {~cur_idx[1:0], 3'b000});
		end else if (cur_idx == 4'(HEADER_LEN)) begin
			tx_byte = id_r;
		end else if (cur_idx == frame_len - 4'd2) begin
			tx_byte = crc_r[15:8];
		end else if (cur_idx == frame_len - 4'd1) begin
			tx_byte = crc_r[7:0];
		end else if (kind_r == KIND_CONTROL_MODE) begin
			tx_byte = modes_r;
		end else begin
			tx_byte = sp_off[0] ? sp[7:0] : sp[15:8];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_r <= 1'b0;
			kind_r <= KIND_STATUS_REQUEST;
			idx_r <= '0;
			crc_r <= 16'hFFFF;
		end else begin
			if (accept) begin
				busy_r <= 1'b1;
				kind_r <= req.kind;
				crc_r <= 16'hFFFF;
			end else if (frame_done) begin
				busy_r <= 1'b0;
			end
			if (tx_start) begin
				idx_r <= cur_idx + 4'd1;
				if (cur_idx >= 4'(HEADER_LEN) && cur_idx < frame_len - 4'd2)
					crc_r <= crc16_next(tx_byte, crc_r);
			end
		end
	end

	// frame payload frozen for the whole frame
	always_ff @(posedge clk) begin
		if (accept) begin
			id_r <= node_id;
			modes_r <= {control_mode[0], control_mode[1], control_mode[2], control_mode[3]};
			setpoint_r <= setpoint;
		end
	end

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx0 (
		.clk(clk),
		.reset(reset),
		.start(tx_start),
		.data(tx_byte),
		.line(tx_o),
		.busy(tx_busy),
		.done(tx_done)
	);

	assign req.busy = busy_r;
	assign req.done = frame_done;
	assign tx_enable = busy_r && !frame_done; // covers the gaps between bytes

endmodule

/* logic/status_receiver.sv */
`timescale 1ns/1ns

module status_receiver #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input logic rx_i,
	input logic [7:0] node_id,
	input hand_bus_pkg::setpoint_t setpoint [hand_bus_pkg::NUM_MOTORS],
	input hand_bus_pkg::mode_t control_mode [hand_bus_pkg::NUM_MOTORS],
	status_if.receiver stat,
	output hand_bus_pkg::setpoint_t position [hand_bus_pkg::NUM_MOTORS],
	output hand_bus_pkg::current_t current [hand_bus_pkg::NUM_MOTORS]
);
	import hand_bus_pkg::*;

	localparam int BODY_LEN = STATUS_RESPONSE_LEN - HEADER_LEN;

	logic rx_valid;
	logic [7:0] rx_data;
	logic [23:0] window; // last three bytes, newest in [7:0]
	logic collecting;
	logic [4:0] cnt;
	logic [15:0] crc_r;
	logic [7:0] body [BODY_LEN-1]; // id up to crc high byte
	logic [7:0] mode_in;
	logic last_byte, frame_good, setpoints_differ;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx0 (
		.clk(clk),
		.reset(reset),
		.line(rx_i),
		.valid(rx_valid),
		.data(rx_data)
	);

	assign last_byte = collecting && rx_valid && cnt == 5'(BODY_LEN - 1);
	assign frame_good = crc_r == {body[BODY_LEN-2], rx_data};
	assign mode_in = {control_mode[0], control_mode[1], control_mode[2], control_mode[3]};

	always_comb begin
		setpoints_differ = 1'b0;
		for (int i = 0; i < NUM_MOTORS; i++) begin
			if ({body[2+2*i], body[3+2*i]} != setpoint[i])
				setpoints_differ = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			window <= '0;
			collecting <= 1'b0;
			cnt <= '0;
			crc_r <= 16'hFFFF;
			stat.resp_ok <= 1'b0;
			stat.crc_error <= 1'b0;
			stat.mode_mismatch <= 1'b0;
			stat.setpoint_mismatch <= 1'b0;
			for (int i = 0; i < NUM_MOTORS; i++) begin
				position[i] <= '0;
				current[i] <= '0;
			end
		end else begin
			stat.resp_ok <= 1'b0;
			stat.crc_error <= 1'b0;
			if (rx_valid) begin
				window <= {window[15:0], rx_data};
				if (!collecting) begin
					if ({window, rx_data} == STATUS_RESPONSE_HEADER) begin
						collecting <= 1'b1;
						cnt <= '0;
						crc_r <= 16'hFFFF;
					end
				end else begin
					cnt <= cnt + 5'd1;
					if (cnt < 5'(BODY_LEN - 2))
						crc_r <= crc16_next(rx_data, crc_r);
					if (last_byte) begin
						collecting <= 1'b0; // back to hunting
						stat.crc_error <= !frame_good;
						if (frame_good && body[0] == node_id) begin
							stat.resp_ok <= 1'b1;
							stat.mode_mismatch <= body[1] != mode_in;
							stat.setpoint_mismatch <= setpoints_differ;
							for (int i = 0; i < NUM_MOTORS; i++) begin
								position[i] <= {body[10+2*i], body[11+2*i]};
								current[i] <= {body[18+2*i], body[19+2*i]};
							end
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid && collecting && !last_byte)
			body[cnt] <= rx_data;
	end

endmodule

/* logic/hand_bus_master.sv */
`timescale 1ns/1ns

module hand_bus_master #(
	parameter int CLKS_PER_BIT = 8,
	parameter int POLL_CYCLES = 1000
) (
	input logic clk,
	input logic reset,
	input logic rx_i,
	input logic [7:0] node_id,
	input hand_bus_pkg::setpoint_t setpoint [hand_bus_pkg::NUM_MOTORS],
	input hand_bus_pkg::mode_t control_mode [hand_bus_pkg::NUM_MOTORS],
	output logic tx_o,
	output logic tx_enable,
	output hand_bus_pkg::setpoint_t position [hand_bus_pkg::NUM_MOTORS],
	output hand_bus_pkg::current_t current [hand_bus_pkg::NUM_MOTORS],
	output logic resp_ok,
	output logic crc_error
);
	import hand_bus_pkg::*;

	// one full response plus a byte of slack
	localparam int TIMEOUT_CYCLES = CLKS_PER_BIT * 10 * (STATUS_RESPONSE_LEN + 1);

	typedef enum logic [1:0] {S_IDLE, S_REQUEST, S_RESPONSE, S_FOLLOW} state_t;

	state_t state;
	logic [31:0] cnt;

	frame_req_if req_bus();
	status_if stat_bus();

	frame_sender #(.CLKS_PER_BIT(CLKS_PER_BIT)) sender0 (
		.clk(clk), .reset(reset), .req(req_bus.sender), .node_id(node_id),
		.setpoint(setpoint), .control_mode(control_mode),
		.tx_o(tx_o), .tx_enable(tx_enable)
	);

	status_receiver #(.CLKS_PER_BIT(CLKS_PER_BIT)) receiver0 (
		.clk(clk), .reset(reset), .rx_i(rx_i), .node_id(node_id),
		.setpoint(setpoint), .control_mode(control_mode),
		.stat(stat_bus.receiver), .position(position), .current(current)
	);

	assign resp_ok = stat_bus.resp_ok;
	assign crc_error = stat_bus.crc_error;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
			cnt <= 32'(POLL_CYCLES - 1);
			req_bus.send <= 1'b0;
			req_bus.kind <= KIND_STATUS_REQUEST;
		end else begin
			req_bus.send <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cnt != 0) begin
						cnt <= cnt - 32'd1;
					end else if (!req_bus.busy) begin
						req_bus.send <= 1'b1;
						req_bus.kind <= KIND_STATUS_REQUEST;
						state <= S_REQUEST;
					end
				end
				S_REQUEST: if (req_bus.done) begin
					cnt <= 32'(TIMEOUT_CYCLES - 1);
					state <= S_RESPONSE;
				end
				S_RESPONSE: begin
					if (stat_bus.resp_ok && (stat_bus.mode_mismatch || stat_bus.setpoint_mismatch)) begin
						req_bus.send <= 1'b1;
						// mode change wins over a setpoint update
						req_bus.kind <= stat_bus.mode_mismatch ? KIND_CONTROL_MODE
							: KIND_HAND_COMMAND;
						state <= S_FOLLOW;
					end else if (stat_bus.resp_ok || stat_bus.crc_error || cnt == 0) begin
						cnt <= 32'(POLL_CYCLES - 1);
						state <= S_IDLE;
					end else begin
						cnt <= cnt - 32'd1;
					end
				end
				default: if (req_bus.done) begin
					cnt <= 32'(POLL_CYCLES - 1);
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

/* tb/tb_hand_bus.sv */
`timescale 1ns/1ns

module tb_hand_bus;
	import hand_bus_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int CLKS_PER_BIT = 8;
	localparam int POLL_CYCLES = 50;
	localparam int TIMEOUT_CYCLES = CLKS_PER_BIT * 10 * (STATUS_RESPONSE_LEN + 1);

	// response variants of the hand model
	localparam int V_MATCH = 0;
	localparam int V_MODE = 1;
	localparam int V_SETPOINT = 2;
	localparam int V_BAD_CRC = 3;
	localparam int V_WRONG_ID = 4;
	localparam int V_SILENT = 5;

	typedef logic [7:0] byte_q_t [$];

	logic clk;
	logic reset;
	logic rx_i;
	logic [7:0] node_id;
	setpoint_t setpoint_in [NUM_MOTORS];
	mode_t control_mode_in [NUM_MOTORS];
	logic tx_o;
	logic tx_enable;
	setpoint_t position [NUM_MOTORS];
	current_t current [NUM_MOTORS];
	logic resp_ok;
	logic crc_error;

	integer seed;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int resp_count = 0;
	int crc_count = 0;
	setpoint_t exp_pos [NUM_MOTORS]; // last accepted response
	current_t exp_cur [NUM_MOTORS];

	hand_bus_master #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.POLL_CYCLES(POLL_CYCLES)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.rx_i(rx_i),
		.node_id(node_id),
		.setpoint(setpoint_in),
		.control_mode(control_mode_in),
		.tx_o(tx_o),
		.tx_enable(tx_enable),
		.position(position),
		.current(current),
		.resp_ok(resp_ok),
		.crc_error(crc_error)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// pulse counts of the two strobes
	always @(posedge clk) begin
		if (resp_ok === 1'b1)
			resp_count = resp_count + 1;
		if (crc_error === 1'b1)
			crc_count = crc_count + 1;
	end

	// ccitt 1021 crc over q[first..last]
	function automatic logic [15:0] crc_over(input byte_q_t q, input int first, input int last);
		logic [15:0] c;
		logic feedback;
		c = 16'hFFFF;
		for (int n = first; n <= last; n++) begin
			for (int b = 7; b >= 0; b--) begin
				feedback = c[15] ^ q[n][b];
				c = {c[14:0], 1'b0};
				if (feedback)
					c = c ^ 16'h1021;
			end
		end
		return c;
	endfunction

	function automatic logic [7:0] pack_modes(input mode_t md [NUM_MOTORS]);
		return {md[0], md[1], md[2], md[3]}; // motor 0 on top
	endfunction

	// expected bytes of an outgoing frame
	function automatic byte_q_t build_frame(input frame_kind_t kind, input logic [7:0] id,
			input setpoint_t sp [NUM_MOTORS], input mode_t md [NUM_MOTORS]);
		byte_q_t q;
		logic [31:0] hdr;
		logic [15:0] crc;
		case (kind)
			KIND_HAND_COMMAND: hdr = HAND_COMMAND_HEADER;
			KIND_CONTROL_MODE: hdr = CONTROL_MODE_HEADER;
			default: hdr = STATUS_REQUEST_HEADER;
		endcase
		for (int i = 3; i >= 0; i--)
			q.push_back(hdr[8*i +: 8]);
		q.push_back(id);
		if (kind == KIND_HAND_COMMAND) begin
			for (int m = 0; m < NUM_MOTORS; m++) begin
				q.push_back(sp[m][15:8]);
				q.push_back(sp[m][7:0]);
			end
		end else if (kind == KIND_CONTROL_MODE) begin
			q.push_back(pack_modes(md));
		end
		crc = crc_over(q, HEADER_LEN, q.size() - 1);
		q.push_back(crc[15:8]);
		q.push_back(crc[7:0]);
		return q;
	endfunction

	function automatic byte_q_t build_response(input logic [7:0] id, input logic [7:0] modes,
			input setpoint_t sp [NUM_MOTORS], input setpoint_t pos [NUM_MOTORS],
			input current_t cur [NUM_MOTORS]);
		byte_q_t q;
		logic [31:0] hdr;
		logic [15:0] crc;
		hdr = STATUS_RESPONSE_HEADER;
		for (int i = 3; i >= 0; i--)
			q.push_back(hdr[8*i +: 8]);
		q.push_back(id);
		q.push_back(modes);
		for (int m = 0; m < NUM_MOTORS; m++) begin
			q.push_back(sp[m][15:8]);
			q.push_back(sp[m][7:0]);
		end
		for (int m = 0; m < NUM_MOTORS; m++) begin
			q.push_back(pos[m][15:8]);
			q.push_back(pos[m][7:0]);
		end
		for (int m = 0; m < NUM_MOTORS; m++) begin
			q.push_back(cur[m][15:8]);
			q.push_back(cur[m][7:0]);
		end
		crc = crc_over(q, HEADER_LEN, q.size() - 1);
		q.push_back(crc[15:8]);
		q.push_back(crc[7:0]);
		return q;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int first_err);
		if (errors == first_err) begin
			tests_passed++;
			$display("[PASS] %s", name);
		end else begin
			tests_failed++;
			$display("[FAIL] %s (%0d errors)", name, errors - first_err);
		end
	endtask

	task automatic randomize_inputs();
		logic [31:0] r;
		@(posedge clk);
		for (int m = 0; m < NUM_MOTORS; m++) begin
			r = $random(seed);
			setpoint_in[m] <= r[15:0];
			control_mode_in[m] <= r[17:16];
		end
		@(negedge clk);
	endtask

	// 8N1 encoder of the hand
	task automatic send_response(input byte_q_t q);
		logic [9:0] frame_bits;
		foreach (q[n]) begin
			frame_bits = {1'b1, q[n], 1'b0};
			for (int i = 0; i < 10; i++) begin
				@(posedge clk);
				rx_i <= frame_bits[i];
				if (i < 9 || n < q.size() - 1)
					repeat (CLKS_PER_BIT - 1) @(posedge clk);
			end
		end
		@(negedge clk);
	endtask

	// hand side decoder sampling tx_o mid-bit on falling edges
	task automatic capture_frame(output byte_q_t q, input int max_wait);
		logic [7:0] b;
		int t;
		bit more;
		bit early;
		q = {};
		t = 0;
		early = 1'b0;
		@(negedge clk);
		while (tx_o !== 1'b0 && t < max_wait) begin
			if (tx_enable !== 1'b0 && !early) begin
				report_error("tx_enable high before the start bit");
				early = 1'b1;
			end
			@(negedge clk);
			t++;
		end
		more = tx_o === 1'b0;
		if (!more)
			report_error("timeout waiting for a frame on tx_o");
		while (more) begin
			if (tx_enable !== 1'b1)
				report_error("tx_enable low during a start bit");
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			if (tx_o !== 1'b0)
				report_error("start bit on tx_o too short");
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				b[i] = tx_o;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (tx_o !== 1'b1)
				report_error("missing stop bit on tx_o");
			q.push_back(b);
			t = 0;
			// next start bit or end of frame
			while (tx_o === 1'b1 && tx_enable === 1'b1 && t < 2 * CLKS_PER_BIT) begin
				@(negedge clk);
				t++;
			end
			if (tx_o === 1'b1 && tx_enable === 1'b1)
				report_error("tx_enable stuck high after the last byte");
			more = tx_o === 1'b0 && tx_enable === 1'b1 && q.size() < STATUS_RESPONSE_LEN;
		end
	endtask

	task automatic compare_frame(input byte_q_t got, input byte_q_t exp, input string label);
		if (got.size() != exp.size()) begin
			report_mismatch({label, " length"}, got.size(), exp.size());
		end else begin
			for (int n = 0; n < exp.size(); n++) begin
				if (got[n] !== exp[n])
					report_mismatch($sformatf("%s byte %0d", label, n),
						32'(got[n]), 32'(exp[n]));
			end
		end
	endtask

	task automatic wait_for_strobe(input int resp_before, input int crc_before);
		int t;
		t = 0;
		while (resp_count == resp_before && crc_count == crc_before
				&& t < 20 * CLKS_PER_BIT) begin
			@(negedge clk);
			t++;
		end
		if (resp_count == resp_before && crc_count == crc_before)
			report_error("timeout waiting for resp_ok or crc_error");
	endtask

	task automatic check_outputs();
		for (int m = 0; m < NUM_MOTORS; m++) begin
			if (position[m] !== exp_pos[m])
				report_mismatch($sformatf("position[%0d]", m),
					32'(position[m]), 32'(exp_pos[m]));
			if (current[m] !== exp_cur[m])
				report_mismatch($sformatf("current[%0d]", m),
					32'(current[m]), 32'(exp_cur[m]));
		end
	endtask

	// one poll cycle as seen by the hand
	task automatic run_cycle(input string name, input int variant);
		byte_q_t resp;
		byte_q_t got;
		setpoint_t sp_resp [NUM_MOTORS];
		setpoint_t pos [NUM_MOTORS];
		current_t cur [NUM_MOTORS];
		logic [7:0] modes;
		logic [7:0] id;
		logic [31:0] r;
		int first_err;
		int resp_before;
		int crc_before;
		int exp_resp;
		int exp_crc;
		time t0;
		bit early_req;
		t0 = $time;
		first_err = errors;
		resp_before = resp_count;
		crc_before = crc_count;
		randomize_inputs();
		for (int m = 0; m < NUM_MOTORS; m++) begin
			sp_resp[m] = setpoint_in[m];
			r = $random(seed);
			pos[m] = r[15:0];
			cur[m] = r[31:16];
		end
		modes = pack_modes(control_mode_in);
		id = node_id;
		if (variant == V_MODE)
			modes = modes ^ 8'h40; // motor 0 differs
		if (variant == V_SETPOINT)
			sp_resp[2] = sp_resp[2] ^ 16'h0100;
		if (variant == V_WRONG_ID)
			id = ~node_id;
		resp = build_response(id, modes, sp_resp, pos, cur);
		if (variant == V_BAD_CRC)
			resp[31] = resp[31] ^ 8'h01;
		if (variant != V_SILENT)
			send_response(resp);
		exp_resp = variant <= V_SETPOINT ? 1 : 0;
		exp_crc = variant == V_BAD_CRC ? 1 : 0;
		if (variant <= V_BAD_CRC)
			wait_for_strobe(resp_before, crc_before);
		if (variant <= V_SETPOINT) begin
			exp_pos = pos;
			exp_cur = cur;
		end
		if (variant == V_MODE) begin
			capture_frame(got, 20 * CLKS_PER_BIT);
			compare_frame(got, build_frame(KIND_CONTROL_MODE, node_id, setpoint_in,
				control_mode_in), "control mode frame");
		end else if (variant == V_SETPOINT) begin
			capture_frame(got, 20 * CLKS_PER_BIT);
			compare_frame(got, build_frame(KIND_HAND_COMMAND, node_id, setpoint_in,
				control_mode_in), "hand command frame");
		end
		if (variant >= V_WRONG_ID) begin
			// bus stays quiet for the whole response timeout
			early_req = 1'b0;
			while ($time - t0 < CLK_PERIOD * TIMEOUT_CYCLES) begin
				if (tx_enable !== 1'b0)
					early_req = 1'b1;
				@(negedge clk);
			end
			if (early_req)
				report_error("status request started before the response timeout");
		end
		capture_frame(got, POLL_CYCLES + 100);
		compare_frame(got, build_frame(KIND_STATUS_REQUEST, node_id, setpoint_in,
			control_mode_in), "next status request");
		if (resp_count - resp_before != exp_resp)
			report_mismatch("resp_ok pulses", resp_count - resp_before, exp_resp);
		if (crc_count - crc_before != exp_crc)
			report_mismatch("crc_error pulses", crc_count - crc_before, exp_crc);
		check_outputs();
		finish_test(name, first_err);
	endtask

	initial begin : main_seq
		byte_q_t got;
		int first_err;
		seed = 32'ha2daebb6;
		reset <= 1'b1;
		rx_i <= 1'b1;
		node_id <= 8'h3C;
		for (int m = 0; m < NUM_MOTORS; m++) begin
			setpoint_in[m] <= '0;
			control_mode_in[m] <= '0;
			exp_pos[m] = '0;
			exp_cur[m] = '0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		first_err = errors;
		if (tx_o !== 1'b1)
			report_mismatch("tx_o", tx_o, 1);
		if (tx_enable !== 1'b0)
			report_mismatch("tx_enable", tx_enable, 0);
		if (resp_ok !== 1'b0)
			report_mismatch("resp_ok", resp_ok, 0);
		if (crc_error !== 1'b0)
			report_mismatch("crc_error", crc_error, 0);
		check_outputs();
		capture_frame(got, POLL_CYCLES + 50);
		compare_frame(got, build_frame(KIND_STATUS_REQUEST, node_id, setpoint_in,
			control_mode_in), "first status request");
		finish_test("status request after reset", first_err);

		run_cycle("matching response", V_MATCH);
		run_cycle("mode mismatch", V_MODE);
		run_cycle("setpoint mismatch", V_SETPOINT);
		run_cycle("bad crc", V_BAD_CRC);
		run_cycle("wrong node id", V_WRONG_ID);
		run_cycle("no response", V_SILENT);
		run_cycle("matching response again", V_MATCH);

		$display("summary: %0d passed, %0d failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* hand_bus.f */
logic/hand_bus_pkg.sv
logic/frame_req_if.sv
logic/status_if.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/frame_sender.sv
logic/status_receiver.sv
logic/hand_bus_master.sv
tb/tb_hand_bus.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -j 0 -f hand_bus.f --top-module tb_hand_bus -o tb_hand_bus
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
./obj_dir/tb_hand_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "Test FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Test OK" sim.log; then
	echo "simulation log has no result line"
	exit 1
fi
exit 0
